//--- audio_pkg.sv
`default_nettype none

package audio_pkg;

  // ======================================================================
  // Data widths shared across the player
  // ======================================================================
  typedef logic signed [7:0] sample_t;
  typedef logic [31:0]       flash_word_t;
  typedef logic [22:0]       flash_addr_t;
  typedef logic [15:0]       period_t;

  // Active low, bit order gfedcba
  typedef logic [6:0] seg_t;

  localparam int SAMPLES_PER_WORD = 4;

  typedef enum logic {
    FETCH_IDLE,
    FETCH_BUS_WAIT
  } fetch_state_t;

  typedef enum logic [1:0] {
    PLAY_STOPPED,
    PLAY_LOAD,
    PLAY_RUN
  } play_state_t;

  // Standard hex glyphs, lower case b and d
  function automatic seg_t hex_to_seg(input logic [3:0] nibble);
    case (nibble)
      4'h0: return 7'b1000000;
      4'h1: return 7'b1111001;
      4'h2: return 7'b0100100;
      4'h3: return 7'b0110000;
      4'h4: return 7'b0011001;
      4'h5: return 7'b0010010;
      4'h6: return 7'b0000010;
      4'h7: return 7'b1111000;
      4'h8: return 7'b0000000;
      4'h9: return 7'b0010000;
      4'hA: return 7'b0001000;
      4'hB: return 7'b0000011;
      4'hC: return 7'b1000110;
      4'hD: return 7'b0100001;
      4'hE: return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- audio_sample_player.sv
`timescale 1ns/1ps
`default_nettype none

module audio_sample_player import audio_pkg::*; #(
  parameter int unsigned DEFAULT_PERIOD = 614,
  parameter int unsigned SPEED_STEP     = 100,
  parameter int unsigned REPEAT_CYCLES  = 5_000_000,
  parameter flash_addr_t LAST_ADDR      = 23'h7FFFF,
  parameter int unsigned REFRESH_CYCLES = 25_000_000
) (
  input  wire logic        CLK_50M,
  input  wire logic        rst_n,
  input  wire logic        key_up,
  input  wire logic        key_down,
  input  wire logic        key_reset,
  input  wire logic        enable,
  input  wire logic        reverse,
  output logic             flash_cyc,
  output logic             flash_stb,
  output flash_addr_t      flash_adr,
  input  wire flash_word_t flash_dat,
  input  wire logic        flash_ack,
  output sample_t          audio_sample,
  output logic             audio_valid,
  output seg_t             hex0,
  output seg_t             hex1,
  output seg_t             hex2,
  output seg_t             hex3,
  output seg_t             hex4,
  output seg_t             hex5
);

  period_t sample_period;

  sample_fetch_if fetch_if ();

  // ======================================================================
  // Input side
  // ======================================================================
  speed_control #(
    .DEFAULT_PERIOD (DEFAULT_PERIOD),
    .SPEED_STEP     (SPEED_STEP),
    .REPEAT_CYCLES  (REPEAT_CYCLES)
  ) speed_control_i (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .key_up        (key_up),
    .key_down      (key_down),
    .key_reset     (key_reset),
    .sample_period (sample_period)
  );

  flash_wb_master flash_wb_master_i (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .fetch     (fetch_if.master),
    .flash_cyc (flash_cyc),
    .flash_stb (flash_stb),
    .flash_adr (flash_adr),
    .flash_dat (flash_dat),
    .flash_ack (flash_ack)
  );

  // Sample stream
  playback_sequencer #(
    .LAST_ADDR (LAST_ADDR)
  ) playback_sequencer_i (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .enable        (enable),
    .reverse       (reverse),
    .sample_period (sample_period),
    .fetch         (fetch_if.sequencer),
    .audio_sample  (audio_sample),
    .audio_valid   (audio_valid)
  );

  // Output side
  hex_display #(
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) hex_display_i (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .sample_period (sample_period),
    .hex0          (hex0),
    .hex1          (hex1),
    .hex2          (hex2),
    .hex3          (hex3),
    .hex4          (hex4),
    .hex5          (hex5)
  );

endmodule

`default_nettype wire

//--- flash_wb_master.sv
`timescale 1ns/1ps
`default_nettype none

module flash_wb_master import audio_pkg::*; (
  input  wire logic          CLK_50M,
  input  wire logic          rst_n,
  sample_fetch_if.master     fetch,
  output logic               flash_cyc,
  output logic               flash_stb,
  output flash_addr_t        flash_adr,
  input  wire flash_word_t   flash_dat,
  input  wire logic          flash_ack
);

  fetch_state_t state;
  flash_addr_t  adr_q;
  flash_word_t  word_q;
  logic         done_q;

  // ======================================================================
  // Single read per request, Wishbone classic
  // ======================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      state  <= FETCH_IDLE;
      done_q <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0;
      case (state)
        FETCH_IDLE:
        begin
          // req is still high while done is being seen, skip that cycle
          if (fetch.req && !done_q)
          begin
            adr_q <= fetch.addr;
            state <= FETCH_BUS_WAIT;
          end
        end
        FETCH_BUS_WAIT:
        begin
          // Slow ack just stretches the cycle
          if (flash_ack)
          begin
            word_q <= flash_dat;
            done_q <= 1'b1;
            state  <= FETCH_IDLE;
          end
        end
        default:
          state <= FETCH_IDLE;
      endcase
    end
  end

  // cyc and stb share the same window
  assign flash_cyc = (state == FETCH_BUS_WAIT);
  assign flash_stb = (state == FETCH_BUS_WAIT);
  assign flash_adr = adr_q;

  assign fetch.word = word_q;
  assign fetch.done = done_q;

endmodule

`default_nettype wire

//--- hex_display.sv
`timescale 1ns/1ps
`default_nettype none

module hex_display import audio_pkg::*; #(
  parameter int unsigned REFRESH_CYCLES = 25_000_000
) (
  input  wire logic    CLK_50M,
  input  wire logic    rst_n,
  input  wire period_t sample_period,
  output seg_t         hex0,
  output seg_t         hex1,
  output seg_t         hex2,
  output seg_t         hex3,
  output seg_t         hex4,
  output seg_t         hex5
);

  localparam int CNT_W = $clog2(REFRESH_CYCLES + 1);

  logic [CNT_W-1:0] refresh_cnt;
  period_t          shown_period;
  logic [23:0]      shown_value;
  seg_t             digit_seg [6];

  // ======================================================================
  // Slow latch so the digits stay readable
  // ======================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      refresh_cnt  <= '0;
      // Period register is already at its default while reset is held
      shown_period <= sample_period;
    end
    else if (refresh_cnt == CNT_W'(REFRESH_CYCLES - 1))
    begin
      refresh_cnt  <= '0;
      shown_period <= sample_period;
    end
    else
      refresh_cnt <= refresh_cnt + 1'b1;
  end

  // Upper two digits always read zero
  assign shown_value = {8'h00, shown_period};

  for (genvar i = 0; i < 6; i++)
  begin : g_digit
    assign digit_seg[i] = hex_to_seg(shown_value[4*i +: 4]);
  end

  assign hex0 = digit_seg[0];
  assign hex1 = digit_seg[1];
  assign hex2 = digit_seg[2];
  assign hex3 = digit_seg[3];
  assign hex4 = digit_seg[4];
  assign hex5 = digit_seg[5];

endmodule

`default_nettype wire

//--- playback_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module playback_sequencer import audio_pkg::*; #(
  parameter flash_addr_t LAST_ADDR = 23'h7FFFF
) (
  input  wire logic      CLK_50M,
  input  wire logic      rst_n,
  input  wire logic      enable,
  input  wire logic      reverse,
  input  wire period_t   sample_period,
  sample_fetch_if.sequencer fetch,
  output sample_t        audio_sample,
  output logic           audio_valid
);

  localparam int               IDX_W    = $clog2(SAMPLES_PER_WORD);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(SAMPLES_PER_WORD - 1);

  play_state_t      state;
  period_t          timer;
  flash_word_t      cur_word;
  flash_word_t      nxt_word;
  logic             cur_rev;
  logic             nxt_rev;
  logic             nxt_valid;
  logic [IDX_W-1:0] byte_idx;
  flash_addr_t      addr_q;
  logic             req_q;
  logic             req_rev;
  logic             first_fetch;
  logic             timer_done;
  logic             want_word;
  logic             raise_req;

  // Byte lane for the idx-th sample of a word
  function automatic sample_t pick_byte(input flash_word_t word, input logic rev,
                                        input logic [IDX_W-1:0] idx);
    logic [IDX_W-1:0] lane;
    lane = rev ? (LAST_IDX - idx) : idx;
    return word[8*lane +: 8];
  endfunction

  function automatic flash_addr_t step_addr(input flash_addr_t addr, input logic rev);
    if (rev)
      return (addr == '0) ? LAST_ADDR : addr - 1'b1;
    return (addr == LAST_ADDR) ? '0 : addr + 1'b1;
  endfunction

  assign timer_done = ({1'b0, timer} + 17'd1) >= {1'b0, sample_period};

  // Prefetch opens once the first byte of the current word is out
  assign want_word = (state == PLAY_LOAD) || (state == PLAY_RUN && byte_idx != '0);
  assign raise_req = enable && want_word && !nxt_valid && !req_q && !fetch.done;

  // ======================================================================
  // Fetch side, next-word buffer and playback FSM
  // ======================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      state       <= PLAY_STOPPED;
      timer       <= '0;
      byte_idx    <= '0;
      nxt_valid   <= 1'b0;
      req_q       <= 1'b0;
      first_fetch <= 1'b1;
      addr_q      <= '0;
      audio_valid <= 1'b0;
    end
    else
    begin
      audio_valid <= 1'b0;

      // Direction is fixed per word at request time
      if (raise_req)
      begin
        req_q       <= 1'b1;
        req_rev     <= reverse;
        first_fetch <= 1'b0;
        addr_q      <= first_fetch ? '0 : step_addr(addr_q, reverse);
      end
      else if (fetch.done)
      begin
        req_q     <= 1'b0;
        nxt_word  <= fetch.word;
        nxt_rev   <= req_rev;
        nxt_valid <= 1'b1;
      end

      case (state)
        PLAY_STOPPED:
        begin
          if (enable)
            state <= PLAY_LOAD;
        end
        PLAY_LOAD:
        begin
          // Late word is emitted once it lands and its sample slot is due
          if (enable && !timer_done)
            timer <= timer + 1'b1;
          else if (enable && nxt_valid)
          begin
            cur_word     <= nxt_word;
            cur_rev      <= nxt_rev;
            nxt_valid    <= 1'b0;
            audio_sample <= pick_byte(nxt_word, nxt_rev, '0);
            audio_valid  <= 1'b1;
            byte_idx     <= IDX_W'(1);
            timer        <= '0;
            state        <= PLAY_RUN;
          end
        end
        PLAY_RUN:
        begin
          if (enable && !timer_done)
            timer <= timer + 1'b1;
          else if (enable)
          begin
            timer        <= '0;
            audio_sample <= pick_byte(cur_word, cur_rev, byte_idx);
            audio_valid  <= 1'b1;
            byte_idx     <= byte_idx + 1'b1;
            if (byte_idx == LAST_IDX)
            begin
              byte_idx <= '0;
              if (nxt_valid)
              begin
                cur_word  <= nxt_word;
                cur_rev   <= nxt_rev;
                nxt_valid <= 1'b0;
              end
              else
                state <= PLAY_LOAD;
            end
          end
        end
        default:
          state <= PLAY_STOPPED;
      endcase
    end
  end

  assign fetch.req  = req_q;
  assign fetch.addr = addr_q;

endmodule

`default_nettype wire

//--- sample_fetch_if.sv
`timescale 1ns/1ps
`default_nettype none

// One word request at a time between sequencer and bus master
interface sample_fetch_if import audio_pkg::*; ();

  logic        req;
  flash_addr_t addr;
  flash_word_t word;
  logic        done;

  modport sequencer (
    output req,
    output addr,
    input  word,
    input  done
  );

  modport master (
    input  req,
    input  addr,
    output word,
    output done
  );

endinterface

`default_nettype wire

//--- sources.f
audio_pkg.sv
sample_fetch_if.sv
speed_control.sv
flash_wb_master.sv
playback_sequencer.sv
hex_display.sv
audio_sample_player.sv
tb_audio_sample_player.sv

//--- speed_control.sv
`timescale 1ns/1ps
`default_nettype none

module speed_control import audio_pkg::*; #(
  parameter int unsigned DEFAULT_PERIOD = 614,
  parameter int unsigned SPEED_STEP     = 100,
  parameter int unsigned REPEAT_CYCLES  = 5_000_000
) (
  input  wire logic CLK_50M,
  input  wire logic rst_n,
  input  wire logic key_up,
  input  wire logic key_down,
  input  wire logic key_reset,
  output period_t   sample_period
);

  localparam int          CNT_W  = $clog2(REPEAT_CYCLES + 1);
  localparam logic [16:0] STEP_X = 17'(SPEED_STEP);

  logic [1:0]       up_sync;
  logic [1:0]       down_sync;
  logic [1:0]       reset_sync;
  logic             reset_prev;
  logic [CNT_W-1:0] repeat_cnt;
  logic             repeat_tick;
  logic             reset_press;
  logic             step_up;
  logic             step_down;
  logic [16:0]      period_dec;
  logic [16:0]      period_inc;

  // ======================================================================
  // Button synchronizers, buttons are active high
  // ======================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      up_sync    <= '0;
      down_sync  <= '0;
      reset_sync <= '0;
      reset_prev <= 1'b0;
    end
    else
    begin
      up_sync    <= {up_sync[0], key_up};
      down_sync  <= {down_sync[0], key_down};
      reset_sync <= {reset_sync[0], key_reset};
      reset_prev <= reset_sync[1];
    end
  end

  assign reset_press = reset_sync[1] & ~reset_prev;

  // Repeat rate for held buttons
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n || repeat_tick)
      repeat_cnt <= '0;
    else
      repeat_cnt <= repeat_cnt + 1'b1;
  end

  assign repeat_tick = (repeat_cnt == CNT_W'(REPEAT_CYCLES - 1));

  // ======================================================================
  // Saturating period register
  // ======================================================================
  assign period_dec = {1'b0, sample_period} - STEP_X;
  assign period_inc = {1'b0, sample_period} + STEP_X;

  // Both held cancel out; a step leaving the legal range is dropped
  assign step_up   = repeat_tick && up_sync[1] && !down_sync[1]
                     && !period_dec[16] && (period_dec >= STEP_X);
  assign step_down = repeat_tick && down_sync[1] && !up_sync[1] && !period_inc[16];

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n || reset_press)
      sample_period <= period_t'(DEFAULT_PERIOD);
    else if (step_up)
      sample_period <= period_dec[15:0];
    else if (step_down)
      sample_period <= period_inc[15:0];
  end

endmodule

`default_nettype wire

//--- tb_audio_sample_player.sv
`timescale 1ns/1ps
`default_nettype none

module tb_audio_sample_player;

  localparam int CYCLE_LIMIT = 20000;
  localparam int LAST_A      = 7;

  logic        CLK_50M;
  logic        rst_n;
  logic        key_up;
  logic        key_down;
  logic        key_reset;
  logic        enable;
  logic        reverse;
  logic        flash_cyc;
  logic        flash_stb;
  logic [22:0] flash_adr;
  logic [31:0] flash_dat;
  logic        flash_ack;
  logic [7:0]  audio_sample;
  logic        audio_valid;
  logic [6:0]  hex [6];

  int          errors;
  int          tests_run;
  int          tests_failed;
  int          test_err_base;
  int          cycles;
  int          samples;
  int          gap;
  int          exp_period;
  int          shown;
  int          prev_shown;
  int          key_mode;
  int          wait_left;
  string       cur_test;
  logic        rst_held;
  logic        spacing_on;
  logic        spacing_armed;
  logic        first_fetch;
  logic [22:0] last_fetch;
  logic [22:0] exp_adr;
  logic [22:0] q_addr [$];
  logic        q_rev [$];
  logic [22:0] cur_addr;
  logic        cur_rev;
  logic [1:0]  byte_idx;
  logic [7:0]  exp_byte;
  logic [6:0]  seg_table [16];

  audio_sample_player #(
    .DEFAULT_PERIOD (20),
    .SPEED_STEP     (4),
    .REPEAT_CYCLES  (50),
    .LAST_ADDR      (23'd7),
    .REFRESH_CYCLES (30)
  ) audio_sample_player_i (
    .CLK_50M (CLK_50M), .rst_n (rst_n),
    .key_up (key_up), .key_down (key_down), .key_reset (key_reset),
    .enable (enable), .reverse (reverse),
    .flash_cyc (flash_cyc), .flash_stb (flash_stb), .flash_adr (flash_adr),
    .flash_dat (flash_dat), .flash_ack (flash_ack),
    .audio_sample (audio_sample), .audio_valid (audio_valid),
    .hex0 (hex[0]), .hex1 (hex[1]), .hex2 (hex[2]),
    .hex3 (hex[3]), .hex4 (hex[4]), .hex5 (hex[5])
  );

  // Flash content rule gives a distinct byte in every lane of addresses 0 to 7
  function automatic logic [7:0] byte_for(input logic [22:0] a, input int k);
    return 8'(((a & 23'h7) << 4) | (k << 1) | 1) ^ 8'h80;
  endfunction

  function automatic logic [31:0] word_for(input logic [22:0] a);
    return {byte_for(a, 3), byte_for(a, 2), byte_for(a, 1), byte_for(a, 0)};
  endfunction

  function automatic logic [22:0] next_addr(input logic [22:0] a, input logic rev);
    if (rev)
      return (a == 0) ? 23'(LAST_A) : a - 1;
    return (a == 23'(LAST_A)) ? 23'd0 : a + 1;
  endfunction

  // Segment pattern decoded to its nibble or -1 for an unknown glyph
  function automatic int seg_value(input logic [6:0] seg);
    for (int i = 0; i < 16; i++)
      if (seg_table[i] == seg)
        return i;
    return -1;
  endfunction

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ======================================================================
  // Flash slave with 0 to 3 wait states
  // ======================================================================
  always @(posedge CLK_50M)
  begin
    flash_ack <= 1'b0;
    if (flash_cyc && flash_stb && !flash_ack)
    begin
      if (wait_left == 0)
      begin
        flash_ack <= 1'b1;
        flash_dat <= word_for(flash_adr);
        wait_left <= $urandom % 4;
      end
      else
        wait_left <= wait_left - 1;
    end
  end

  // ======================================================================
  // Scoreboard for fetch addresses and the sample stream
  // ======================================================================
  always @(posedge CLK_50M)
  begin
    cycles <= cycles + 1;
    rst_held <= !rst_n;
    gap <= audio_valid ? 1 : gap + 1;
    spacing_armed <= spacing_on && (spacing_armed || audio_valid);
    if (!rst_n)
    begin
      first_fetch = 1'b1;
      byte_idx = 2'd0;
    end
    else
    begin
      if (flash_cyc && flash_ack)
      begin
        exp_adr = first_fetch ? 23'd0 : next_addr(last_fetch, reverse);
        assert (flash_adr == exp_adr)
        else
        begin
          errors++;
          $display("Mismatch %s fetch address expected %0h actual %0h",
                   cur_test, exp_adr, flash_adr);
        end
        first_fetch = 1'b0;
        last_fetch = flash_adr;
        q_addr.push_back(flash_adr);
        q_rev.push_back(reverse);
      end
      if (audio_valid)
      begin
        samples <= samples + 1;
        if (byte_idx == 0)
        begin
          if (q_addr.size() == 0)
          begin
            errors++;
            $display("%s: a sample came out before any word was fetched", cur_test);
          end
          else
          begin
            cur_addr = q_addr.pop_front();
            cur_rev = q_rev.pop_front();
          end
        end
        exp_byte = byte_for(cur_addr, cur_rev ? 3 - byte_idx : byte_idx);
        assert (audio_sample == exp_byte)
        else
        begin
          errors++;
          $display("Mismatch %s sample expected %02h actual %02h",
                   cur_test, exp_byte, audio_sample);
        end
        byte_idx = byte_idx + 1;
      end
    end
  end

  // Each change of the displayed period is one step in the held direction
  always @(posedge CLK_50M)
  begin
    shown = 0;
    for (int i = 5; i >= 0; i--)
      shown = (shown << 4) | (seg_value(hex[i]) & 4'hF);
    if (rst_n && rst_held === 1'b0 && shown != prev_shown)
    begin
      exp_period = (key_mode == 1) ? prev_shown - 4 :
                   (key_mode == 2) ? prev_shown + 4 : 20;
      assert (shown == exp_period)
      else
      begin
        errors++;
        $display("Mismatch %s display step expected %0d actual %0d",
                 cur_test, exp_period, shown);
      end
    end
    prev_shown = shown;
  end

  // Bus and strobe rules
  assert property (@(posedge CLK_50M) disable iff (!rst_n) flash_stb |-> flash_cyc)
  else
  begin
    errors++;
    $display("%s: flash_stb high without flash_cyc", cur_test);
  end

  assert property (@(posedge CLK_50M) disable iff (!rst_n)
                   flash_stb && !flash_ack |=> flash_stb && $stable(flash_adr))
  else
  begin
    errors++;
    $display("%s: bus cycle dropped or address moved before ack", cur_test);
  end

  assert property (@(posedge CLK_50M) disable iff (!rst_n)
                   flash_stb && flash_ack |=> !flash_stb && !flash_cyc)
  else
  begin
    errors++;
    $display("%s: cyc or stb still high in the cycle after ack", cur_test);
  end

  assert property (@(posedge CLK_50M) rst_held && !rst_n |->
                   !flash_cyc && !flash_stb && !audio_valid)
  else
  begin
    errors++;
    $display("%s: bus or audio strobe active during reset", cur_test);
  end

  assert property (@(posedge CLK_50M) disable iff (!rst_n) !$past(enable) |-> !audio_valid)
  else
  begin
    errors++;
    $display("%s: audio_valid pulsed while paused", cur_test);
  end

  assert property (@(posedge CLK_50M) disable iff (!rst_n)
                   audio_valid && spacing_armed |-> gap >= 20)
  else
  begin
    errors++;
    $display("Mismatch %s sample spacing expected >= 20 actual %0d", cur_test, gap);
  end

  always @(posedge CLK_50M)
  begin
    if (cycles == CYCLE_LIMIT)
    begin
      $display("Timeout after %0d cycles in test %s", CYCLE_LIMIT, cur_test);
      $display("sim failed");
      $finish;
    end
  end

  task automatic wait_samples(input int n);
    int target;
    target = samples + n;
    while (samples < target)
      @(posedge CLK_50M);
  endtask

  task automatic check_display(input int expected);
    assert (shown == expected)
    else
    begin
      errors++;
      $display("Mismatch %s display expected %0d actual %0d", cur_test, expected, shown);
    end
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != test_err_base)
      tests_failed++;
    $display("test %s: %s", cur_test, (errors == test_err_base) ? "ok" : "FAILED");
    test_err_base = errors;
  endtask

  initial
  begin
    void'($urandom(32'h60f3));
    seg_table = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                  7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};
    {rst_n, key_up, key_down, key_reset, enable, reverse} = '0;
    {flash_ack, rst_held, spacing_on, spacing_armed} = '0;
    flash_dat = '0;
    {errors, tests_run, tests_failed, test_err_base, cycles, samples, gap} = '0;
    {key_mode, prev_shown} = '0;
    wait_left = $urandom % 4;
    cur_test = "forward";
    repeat (10) @(posedge CLK_50M);
    rst_n <= 1'b1;
    enable <= 1'b1;
    spacing_on <= 1'b1;
    wait_samples(40);
    end_test();

    cur_test = "pause";
    spacing_on <= 1'b0;
    enable <= 1'b0;
    repeat (100) @(posedge CLK_50M);
    enable <= 1'b1;
    wait_samples(8);
    end_test();

    // Let any open fetch finish before flipping direction
    cur_test = "reverse";
    enable <= 1'b0;
    repeat (20) @(posedge CLK_50M);
    reverse <= 1'b1;
    enable <= 1'b1;
    wait_samples(40);
    end_test();

    cur_test = "speed";
    key_mode = 1;
    key_up <= 1'b1;
    repeat (600) @(posedge CLK_50M);
    key_up <= 1'b0;
    repeat (70) @(posedge CLK_50M);
    check_display(4);
    // Two or three steps up, so the period stays below its default
    key_mode = 2;
    key_down <= 1'b1;
    repeat (110) @(posedge CLK_50M);
    key_down <= 1'b0;
    repeat (70) @(posedge CLK_50M);
    assert (shown > 4 && shown < 20 && shown % 4 == 0)
    else
    begin
      errors++;
      $display("%s: holding down did not raise the period, shows %0d", cur_test, shown);
    end
    key_mode = 3;
    key_reset <= 1'b1;
    repeat (3) @(posedge CLK_50M);
    key_reset <= 1'b0;
    repeat (70) @(posedge CLK_50M);
    check_display(20);
    end_test();

    $display("tests: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire
